//--- hdl/game_pkg.sv
`default_nettype none

package game_pkg;

   // ####################################################################
   // Field geometry
   // ####################################################################
   localparam int POS_W = 12;
   localparam logic [POS_W-1:0] NET_X = 12'd512;     // x below this is player 1's side
   localparam logic [POS_W-1:0] GROUND_Y = 12'd679;

   // Rule limits
   localparam logic [2:0] MAX_TOUCHES = 3'd4;
   localparam logic [3:0] WIN_SCORE = 4'd15;
   localparam int RALLY_W = 16;

   // ####################################################################
   // Register map and word layouts
   // ####################################################################
   localparam logic [3:0] REG_SAMPLE = 4'h0;      // Write only
   localparam logic [3:0] REG_STATUS = 4'h4;      // Read only
   localparam logic [3:0] REG_RALLY = 4'h8;       // Read only
   localparam logic [3:0] REG_IRQ_CLEAR = 4'hC;   // Write only

   localparam int SAMPLE_X_LSB = 0;
   localparam int SAMPLE_Y_LSB = 12;
   localparam int SAMPLE_COL1_BIT = 24;
   localparam int SAMPLE_COL2_BIT = 25;

   localparam int STAT_S1_LSB = 0;
   localparam int STAT_S2_LSB = 4;
   localparam int STAT_WINNER_BIT = 8;            // 0 when player 1 took the last point
   localparam int STAT_END_BIT = 9;
   localparam int STAT_IRQ_BIT = 10;
   localparam int STAT_PHASE_LSB = 11;

   // Game phases
   localparam logic [1:0] PHASE_SERVE = 2'd0;
   localparam logic [1:0] PHASE_RALLY = 2'd1;
   localparam logic [1:0] PHASE_OVER = 2'd2;

endpackage

`default_nettype wire

//--- hdl/apb_sample_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_sample_port (
   input  logic                       clk_div,
   input  logic                       rst,
   input  logic                       psel,
   input  logic                       penable,
   input  logic                       pwrite,
   input  logic [3:0]                 paddr,
   input  logic [31:0]                pwdata,
   output logic [31:0]                prdata,
   output logic                       pready,
   output logic                       pslverr,
   input  logic [31:0]                status_word,
   input  logic [31:0]                rally_word,
   output logic                       sample_valid,
   output logic [game_pkg::POS_W-1:0] sample_x,
   output logic [game_pkg::POS_W-1:0] sample_y,
   output logic                       col1,
   output logic                       col2,
   output logic                       irq_clear
);

   import game_pkg::*;

   logic        setup_phase;
   logic        access_phase;
   logic        wr_ok;          // Offset takes writes
   logic        rd_ok;          // Offset takes reads
   logic        wr_done;
   logic [31:0] rd_data;

   assign setup_phase = psel && !penable;
   assign access_phase = psel && penable;

   assign wr_ok = (paddr == REG_SAMPLE) || (paddr == REG_IRQ_CLEAR);
   assign rd_ok = (paddr == REG_STATUS) || (paddr == REG_RALLY);

   // Error transfers never reach here since pslverr is high with pready
   assign wr_done = access_phase && pwrite && pready && !pslverr;

   always_comb begin
      case (paddr)
         REG_STATUS: rd_data = status_word;
         REG_RALLY:  rd_data = rally_word;
         default:    rd_data = '0;
      endcase
   end

   // ####################################################################
   // Handshake
   // ####################################################################
   always_ff @(posedge clk_div) begin
      if (rst) begin
         pready <= 1'b0;
         pslverr <= 1'b0;
      end else if (setup_phase && pwrite) begin
         pready <= 1'b1;            // Write completes in first access cycle
         pslverr <= !wr_ok;
      end else if (access_phase && !pwrite && !pready) begin
         pready <= 1'b1;            // One wait state for reads
         pslverr <= !rd_ok;
      end else begin
         pready <= 1'b0;
         pslverr <= 1'b0;
      end
   end

   // Read data goes out with pready
   always_ff @(posedge clk_div) begin
      if (access_phase && !pwrite && !pready) begin
         prdata <= rd_data;
      end
   end

   // ####################################################################
   // Write decode
   // ####################################################################
   always_ff @(posedge clk_div) begin
      if (rst) begin
         sample_valid <= 1'b0;
         irq_clear <= 1'b0;
      end else begin
         sample_valid <= wr_done && (paddr == REG_SAMPLE);
         irq_clear <= wr_done && (paddr == REG_IRQ_CLEAR) && pwdata[0];
      end
   end

   always_ff @(posedge clk_div) begin
      if (wr_done && (paddr == REG_SAMPLE)) begin
         sample_x <= pwdata[SAMPLE_X_LSB +: POS_W];
         sample_y <= pwdata[SAMPLE_Y_LSB +: POS_W];
         col1 <= pwdata[SAMPLE_COL1_BIT];
         col2 <= pwdata[SAMPLE_COL2_BIT];
      end
   end

   // Host protocol checks
   a_penable_needs_psel: assert property (
      @(posedge clk_div) disable iff (rst)
      penable |-> psel
   );

   a_paddr_stable: assert property (
      @(posedge clk_div) disable iff (rst)
      (psel && penable) |-> $stable(paddr)
   );

endmodule

`default_nettype wire

//--- hdl/rally_judge.sv
`timescale 1ns/1ps
`default_nettype none

module rally_judge (
   input  logic                       clk_div,
   input  logic                       rst,
   input  logic                       sample_valid,
   input  logic [game_pkg::POS_W-1:0] sample_x,
   input  logic [game_pkg::POS_W-1:0] sample_y,
   input  logic                       col1,
   input  logic                       col2,
   output logic [1:0]                 phase,
   output logic [3:0]                 score1,
   output logic [3:0]                 score2,
   output logic                       last_winner,
   output logic                       endgame,
   output logic                       point_pulse
);

   import game_pkg::*;

   logic       on_ground;
   logic       far_side;        // Ball on player 2's side
   logic [2:0] touch1;
   logic [2:0] touch2;
   logic [2:0] touch1_nxt;
   logic [2:0] touch2_nxt;
   logic       point_won;
   logic       winner;          // 0 is player 1
   logic [3:0] score1_nxt;
   logic [3:0] score2_nxt;

   assign on_ground = (sample_y == GROUND_Y);
   assign far_side = (sample_x >= NET_X);

   // A touch counts only on the player's own side and off the ground
   assign touch1_nxt = touch1 + {2'b00, col1 && !far_side && !on_ground};
   assign touch2_nxt = touch2 + {2'b00, col2 && far_side && !on_ground};

   // ####################################################################
   // Point rules
   // ####################################################################
   always_comb begin
      point_won = 1'b1;
      winner = 1'b0;
      if (on_ground) begin
         winner = !far_side;        // Far side of the ball takes it
      end else if (touch1_nxt == MAX_TOUCHES) begin
         winner = 1'b1;
      end else if (touch2_nxt == MAX_TOUCHES) begin
         winner = 1'b0;
      end else begin
         point_won = 1'b0;
      end
   end

   assign score1_nxt = score1 + {3'b000, !winner};
   assign score2_nxt = score2 + {3'b000, winner};

   // ####################################################################
   // Rally FSM
   // ####################################################################
   always_ff @(posedge clk_div) begin
      if (rst) begin
         phase <= PHASE_SERVE;
         touch1 <= '0;
         touch2 <= '0;
         score1 <= '0;
         score2 <= '0;
         last_winner <= 1'b0;
         endgame <= 1'b0;
         point_pulse <= 1'b0;
      end else begin
         point_pulse <= 1'b0;
         if (sample_valid) begin
            case (phase)
               PHASE_SERVE: begin
                  if (col1 || col2) begin  // Any collision is a serve
                     touch1 <= '0;
                     touch2 <= '0;
                     phase <= PHASE_RALLY;
                  end
               end
               PHASE_RALLY: begin
                  touch1 <= touch1_nxt;
                  touch2 <= touch2_nxt;
                  if (point_won) begin
                     point_pulse <= 1'b1;
                     last_winner <= winner;
                     score1 <= score1_nxt;
                     score2 <= score2_nxt;
                     if ((score1_nxt == WIN_SCORE) || (score2_nxt == WIN_SCORE)) begin
                        phase <= PHASE_OVER;
                        endgame <= 1'b1;
                     end else begin
                        phase <= PHASE_SERVE;
                     end
                  end
               end
               PHASE_OVER: begin
                  // Held until reset
               end
               default: phase <= PHASE_SERVE;
            endcase
         end
      end
   end

   // A winning score is final, so no score wraps past the limit
   a_score_limit: assert property (
      @(posedge clk_div) disable iff (rst)
      ((score1 == WIN_SCORE) || (score2 == WIN_SCORE))
         |=> ($stable(score1) && $stable(score2))
   );

   a_single_point_pulse: assert property (
      @(posedge clk_div) disable iff (rst)
      point_pulse |=> !point_pulse
   );

endmodule

`default_nettype wire

//--- hdl/score_reporter.sv
`timescale 1ns/1ps
`default_nettype none

module score_reporter (
   input  logic        clk_div,
   input  logic        rst,
   input  logic        sample_valid,
   input  logic [1:0]  phase,
   input  logic [3:0]  score1,
   input  logic [3:0]  score2,
   input  logic        last_winner,
   input  logic        endgame,
   input  logic        point_pulse,
   input  logic        irq_clear,
   output logic        irq,
   output logic [31:0] status_word,
   output logic [31:0] rally_word
);

   import game_pkg::*;

   logic [RALLY_W-1:0] rally_cnt;     // Samples seen in the current rally
   logic [RALLY_W-1:0] rally_len;

   // ####################################################################
   // Rally length and interrupt
   // ####################################################################
   always_ff @(posedge clk_div) begin
      if (rst) begin
         rally_cnt <= '0;
         rally_len <= '0;
         irq <= 1'b0;
      end else begin
         if (point_pulse) begin
            rally_len <= rally_cnt;
            rally_cnt <= '0;
         end else if (sample_valid && (phase == PHASE_RALLY)) begin
            rally_cnt <= rally_cnt + 1'b1;   // Ending sample included
         end

         if (point_pulse) begin
            irq <= 1'b1;                    // Set beats clear
         end else if (irq_clear) begin
            irq <= 1'b0;
         end
      end
   end

   // Status packing
   always_comb begin
      status_word = '0;
      status_word[STAT_S1_LSB +: 4] = score1;
      status_word[STAT_S2_LSB +: 4] = score2;
      status_word[STAT_WINNER_BIT] = last_winner;
      status_word[STAT_END_BIT] = endgame;
      status_word[STAT_IRQ_BIT] = irq;
      status_word[STAT_PHASE_LSB +: 2] = phase;
   end

   assign rally_word = {{(32-RALLY_W){1'b0}}, rally_len};

   // The point has left the rally and no sample is lost to the counter
   a_point_ends_rally: assert property (
      @(posedge clk_div) disable iff (rst)
      point_pulse |-> (!sample_valid && (phase != PHASE_RALLY))
   );

endmodule

`default_nettype wire

//--- hdl/volley_judge_top.sv
`timescale 1ns/1ps
`default_nettype none

module volley_judge_top (
   input  logic        clk_div,
   input  logic        rst,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [3:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        irq
);

   import game_pkg::*;

   // Sample path
   logic             sample_valid;
   logic [POS_W-1:0] sample_x;
   logic [POS_W-1:0] sample_y;
   logic             col1;
   logic             col2;
   logic             irq_clear;

   // Judge results
   logic [1:0]       phase;
   logic [3:0]       score1;
   logic [3:0]       score2;
   logic             last_winner;
   logic             endgame;
   logic             point_pulse;

   // Readback words
   logic [31:0]      status_word;
   logic [31:0]      rally_word;

   apb_sample_port u_apb_sample_port (
      .clk_div      (clk_div),
      .rst          (rst),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .status_word  (status_word),
      .rally_word   (rally_word),
      .sample_valid (sample_valid),
      .sample_x     (sample_x),
      .sample_y     (sample_y),
      .col1         (col1),
      .col2         (col2),
      .irq_clear    (irq_clear)
   );

   rally_judge u_rally_judge (
      .clk_div      (clk_div),
      .rst          (rst),
      .sample_valid (sample_valid),
      .sample_x     (sample_x),
      .sample_y     (sample_y),
      .col1         (col1),
      .col2         (col2),
      .phase        (phase),
      .score1       (score1),
      .score2       (score2),
      .last_winner  (last_winner),
      .endgame      (endgame),
      .point_pulse  (point_pulse)
   );

   score_reporter u_score_reporter (
      .clk_div      (clk_div),
      .rst          (rst),
      .sample_valid (sample_valid),
      .phase        (phase),
      .score1       (score1),
      .score2       (score2),
      .last_winner  (last_winner),
      .endgame      (endgame),
      .point_pulse  (point_pulse),
      .irq_clear    (irq_clear),
      .irq          (irq),
      .status_word  (status_word),
      .rally_word   (rally_word)
   );

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
   output logic clk_div,
   output logic rst
);

   localparam int RESET_CYCLES = 16;

   initial begin
      clk_div = 1'b0;
      forever begin
         #4 clk_div = ~clk_div;     // 8 ns period
      end
   end

   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) begin
         @(posedge clk_div);
      end
      #1 rst = 1'b0;
   end

endmodule

`default_nettype wire

//--- bench/apb_host_tasks.svh
`ifndef APB_HOST_TASKS_SVH
`define APB_HOST_TASKS_SVH

localparam int APB_TIMEOUT = 16;    // Cycles to wait for pready

int error_count = 0;
int check_count = 0;
int test_count = 0;
int test_err_base = 0;

task automatic note_error(input string msg);
   error_count++;
   $display("Error at %0t: %s", $time, msg);
endtask

task automatic end_test(input string name);
   int errs;
   errs = error_count - test_err_base;
   test_count++;
   $display("Test %0d %s: %s, %0d errors", test_count, name,
            (errs == 0) ? "passed" : "failed", errs);
   test_err_base = error_count;
endtask

// ######################################################################
// APB host driving inputs 1 ns after the rising edge
// ######################################################################
task automatic apb_transfer(input logic is_write, input logic [3:0] addr,
                            input logic [31:0] wdata);
   int waits;
   psel = 1'b1;
   penable = 1'b0;
   pwrite = is_write;
   paddr = addr;
   pwdata = wdata;
   @(posedge clk_div);
   #1;
   penable = 1'b1;
   waits = 0;
   while (!pready && waits < APB_TIMEOUT) begin
      @(posedge clk_div);
      #1;
      waits++;
   end
   if (!pready) begin
      stop_with_failure($sformatf("no pready within %0d cycles at offset 0x%h",
                                  APB_TIMEOUT, addr));
   end else begin
      xfer_write = is_write;      // Held over the completing edge
      xfer_addr = addr;
      xfer_data = prdata;
      xfer_err = pslverr;
      xfer_waits = waits;
      xfer_done = 1'b1;
      @(posedge clk_div);
      #1;
      xfer_done = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   end
endtask

task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
   apb_transfer(1'b1, addr, data);
   @(posedge clk_div);    // Idle cycle between writes
   #1;
endtask

task automatic read_reg(input logic [3:0] addr);
   apb_transfer(1'b0, addr, 32'd0);
   check_count++;
endtask

`endif

//--- bench/tb_volley_judge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_volley_judge;

   import game_pkg::*;

   logic        clk_div;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [3:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        irq;

   // Last completed transfer
   logic        xfer_done;
   logic        xfer_write;
   logic [3:0]  xfer_addr;
   logic [31:0] xfer_data;
   logic        xfer_err;
   int          xfer_waits;
   logic        access_ok;

   // Reference model of the referee
   logic [1:0]  m_phase;
   logic [3:0]  m_score1;
   logic [3:0]  m_score2;
   logic        m_winner;
   logic        m_end;
   logic        m_irq;
   logic [15:0] m_rally_len;
   int          m_touch1;
   int          m_touch2;
   int          m_rally_cnt;
   logic [31:0] exp_status;

   assign exp_status = {19'd0, m_phase, m_irq, m_end, m_winner, m_score2, m_score1};
   assign access_ok = xfer_write ? (xfer_addr == REG_SAMPLE || xfer_addr == REG_IRQ_CLEAR)
                                 : (xfer_addr == REG_STATUS || xfer_addr == REG_RALLY);

   clock_gen u_clock_gen (
      .clk_div (clk_div),
      .rst     (rst)
   );

   volley_judge_top u_volley_judge_top (
      .clk_div (clk_div),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .irq     (irq)
   );

   task automatic stop_with_failure(input string why);
      $display("Run stopped, %s", why);
      $display("TEST FAILED");
      $finish;
   endtask

   `include "apb_host_tasks.svh"

   // ######################################################################
   // Checks on every completed transfer
   // ######################################################################
   a_status_read: assert property (
      @(posedge clk_div) disable iff (rst)
      (xfer_done && !xfer_write && xfer_addr == REG_STATUS) |-> (xfer_data == exp_status)
   ) else note_error($sformatf("STATUS read 0x%h, expected 0x%h", xfer_data, exp_status));

   a_rally_read: assert property (
      @(posedge clk_div) disable iff (rst)
      (xfer_done && !xfer_write && xfer_addr == REG_RALLY) |-> (xfer_data == {16'd0, m_rally_len})
   ) else note_error($sformatf("RALLY read 0x%h, expected 0x%h", xfer_data, m_rally_len));

   a_error_response: assert property (
      @(posedge clk_div) disable iff (rst)
      xfer_done |-> (xfer_err == !access_ok)
   ) else note_error($sformatf("pslverr %b at offset 0x%h", xfer_err, xfer_addr));

   a_wait_states: assert property (
      @(posedge clk_div) disable iff (rst)
      xfer_done |-> (xfer_waits == (xfer_write ? 0 : 1))
   ) else note_error($sformatf("%0d wait states at offset 0x%h", xfer_waits, xfer_addr));

   a_irq_level: assert property (
      @(posedge clk_div) disable iff (rst)
      xfer_done |-> (irq == m_irq)
   ) else note_error($sformatf("irq is %b, expected %b", irq, m_irq));

   function automatic int side_x(input logic far);
      return far ? int'($urandom_range(1023, 512)) : int'($urandom_range(511, 0));
   endfunction

   function automatic int air_y();
      return int'($urandom_range(678, 0));
   endfunction

   // Sends one sample and applies the game rules to the model
   task automatic play_sample(input int x, input int y, input logic c1, input logic c2);
      logic ground;
      logic far;
      write_reg(REG_SAMPLE, {6'd0, c2, c1, 12'(y), 12'(x)});
      ground = (y == int'(GROUND_Y));
      far = (x >= int'(NET_X));
      if (m_phase == PHASE_SERVE && (c1 || c2)) begin
         m_touch1 = 0;
         m_touch2 = 0;
         m_phase = PHASE_RALLY;
      end else if (m_phase == PHASE_RALLY) begin
         m_rally_cnt++;
         m_touch1 += int'(c1 && !far && !ground);
         m_touch2 += int'(c2 && far && !ground);
         if (ground || m_touch1 == 4 || m_touch2 == 4) begin
            m_winner = ground ? !far : (m_touch1 == 4);
            if (m_winner) begin
               m_score2++;
            end else begin
               m_score1++;
            end
            m_irq = 1'b1;
            m_rally_len = 16'(m_rally_cnt);
            m_rally_cnt = 0;
            m_end = (m_score1 == WIN_SCORE) || (m_score2 == WIN_SCORE);
            m_phase = m_end ? PHASE_OVER : PHASE_SERVE;
         end
      end
   endtask

   // ######################################################################
   // Test sequences
   // ######################################################################
   task automatic run_tests();
      int   steps;
      logic who;
      read_reg(REG_STATUS);
      read_reg(REG_RALLY);
      end_test("reset values");

      play_sample(side_x(1'b0), air_y(), 1'b0, 1'b0);
      play_sample(side_x(1'b1), int'(GROUND_Y), 1'b0, 1'b0);   // Ground before any serve
      read_reg(REG_STATUS);
      play_sample(side_x(1'b0), air_y(), 1'b1, 1'b0);
      play_sample(side_x(1'b1), air_y(), 1'b0, 1'b0);
      play_sample(int'($urandom_range(1023, 0)), int'(GROUND_Y), 1'b0, 1'b0);
      read_reg(REG_STATUS);
      read_reg(REG_RALLY);
      end_test("serve and ground point");

      play_sample(side_x(1'b1), air_y(), 1'b0, 1'b1);          // Player 2 serves
      repeat (3) begin
         play_sample(side_x(1'b0), air_y(), 1'b1, 1'b0);
      end
      read_reg(REG_STATUS);
      play_sample(side_x(1'b1), air_y(), 1'b1, 1'b0);          // Wrong side
      play_sample(side_x(1'b0), air_y(), 1'b0, 1'b1);
      read_reg(REG_STATUS);
      play_sample(side_x(1'b0), air_y(), 1'b1, 1'b0);
      read_reg(REG_STATUS);
      read_reg(REG_RALLY);
      end_test("touch limit");

      write_reg(REG_IRQ_CLEAR, 32'h0000_0002);                  // Bit 0 low keeps irq
      read_reg(REG_STATUS);
      write_reg(REG_IRQ_CLEAR, 32'h0000_0001);
      m_irq = 1'b0;
      read_reg(REG_STATUS);
      write_reg(REG_STATUS, 32'hFFFF_FFFF);
      write_reg(REG_RALLY, 32'hFFFF_FFFF);
      write_reg(4'h2, 32'h0102_A7FF);
      read_reg(REG_SAMPLE);
      read_reg(REG_IRQ_CLEAR);
      read_reg(4'h6);
      read_reg(REG_STATUS);
      read_reg(REG_RALLY);
      end_test("irq clear and bus errors");

      steps = 0;
      while (m_phase != PHASE_OVER && steps < 4000) begin
         who = 1'($urandom_range(1, 0));
         if (m_phase == PHASE_SERVE) begin
            play_sample(side_x(who), air_y(), !who, who);
         end else if ($urandom_range(7, 0) == 0) begin
            play_sample(int'($urandom_range(1023, 0)), int'(GROUND_Y), 1'b0, 1'b0);
         end else begin
            play_sample(side_x(who), air_y(), 1'($urandom_range(1, 0)),
                        1'($urandom_range(1, 0)));
         end
         if (m_irq) begin
            read_reg(REG_STATUS);
            read_reg(REG_RALLY);
            write_reg(REG_IRQ_CLEAR, 32'h0000_0001);
            m_irq = 1'b0;
         end
         steps++;
      end
      if (!m_end) begin
         error_count++;
         $display("Game did not reach the winning score after %0d samples", steps);
      end
      read_reg(REG_STATUS);
      play_sample(side_x(1'b0), air_y(), 1'b1, 1'b1);
      play_sample(side_x(1'b1), int'(GROUND_Y), 1'b0, 1'b0);
      read_reg(REG_STATUS);
      read_reg(REG_RALLY);
      end_test("full game");
   endtask

   initial begin
      int waited;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = 4'h0;
      pwdata = 32'd0;
      xfer_done = 1'b0;
      xfer_write = 1'b0;
      xfer_addr = 4'h0;
      xfer_data = 32'd0;
      xfer_err = 1'b0;
      xfer_waits = 0;
      m_phase = PHASE_SERVE;
      m_score1 = 4'd0;
      m_score2 = 4'd0;
      m_winner = 1'b0;
      m_end = 1'b0;
      m_irq = 1'b0;
      m_rally_len = 16'd0;
      m_touch1 = 0;
      m_touch2 = 0;
      m_rally_cnt = 0;
      void'($urandom(32'ha724));   // Seeds the generator once
      waited = 0;
      #1;
      while (rst && waited < 64) begin
         @(posedge clk_div);
         waited++;
      end
      if (rst) begin
         stop_with_failure("reset was never released");
      end else begin
         @(posedge clk_div);
         #1;
         run_tests();
         $display("Done: %0d tests, %0d reads checked, %0d errors",
                  test_count, check_count, error_count);
         if (error_count == 0) begin
            $display("TEST OK");
         end else begin
            $display("TEST FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- src.f
+incdir+bench
hdl/game_pkg.sv
hdl/apb_sample_port.sv
hdl/rally_judge.sv
hdl/score_reporter.sv
hdl/volley_judge_top.sv
bench/clock_gen.sv
bench/tb_volley_judge.sv

//--- run_sim.sh
#!/bin/sh
# Builds the volley judge testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_volley_judge -f src.f \
   -Mdir "$BUILD_DIR" -o sim_volley_judge
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/sim_volley_judge" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
   exit 0
fi
echo "No pass line in $LOG"
exit 1
